// File: rtl/bp_macros.svh
// Table sizes, RISC-V control-flow opcodes, counter reset value and fall-through step
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// The direct-mapped BTB is indexed by PC bits 2 and up
`define BP_BTB_ENTRIES 32
`define BP_BTB_IDX_BITS $clog2(`BP_BTB_ENTRIES)

// The global history width is also the PHT index width (32 counters)
`define BP_GHR_BITS 5
`define BP_PHT_ENTRIES (1 << `BP_GHR_BITS)

// Major opcodes of the RISC-V control-flow instructions
`define BP_OP_JAL 7'b1101111
`define BP_OP_JALR 7'b1100111
`define BP_OP_BRANCH 7'b1100011

// Two-bit counters come out of reset weakly not-taken
`define BP_PHT_INIT 2'b01

// Byte step to the next sequential instruction
`define BP_INSTR_BYTES 32'd4

`endif

// File: rtl/bp_pkg.sv
// Package with the control-flow kind enum and the BTB entry struct
package bp_pkg;

    // Control-flow class of an instruction
    // Jumps are always taken, branches follow the PHT counter
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_BRANCH = 2'd1,
        BR_JUMP   = 2'd2
    } br_kind_e;

    // One BTB word of 67 bits in total
    // The tag holds the whole PC, so aliasing between PCs that share an index never hits
    typedef struct packed {
        logic        valid;
        logic [31:0] tag;
        logic [31:0] target;
        br_kind_e    kind;
    } btb_entry_t;

endpackage

// File: rtl/bp_predictor.sv
// Fetch-stage predictor: direct-mapped BTB, gshare PHT of two-bit counters and global history
`timescale 1ns/1ns

`include "bp_macros.svh"

module bp_predictor (
    input  logic                        clk,
    input  logic                        reset_i,
    // Fetch lookup
    input  logic [31:0]                 pc_i,
    output logic                        pred_taken_o,
    output logic [31:0]                 pred_target_o,
    output logic                        hit_o,
    output logic [`BP_GHR_BITS-1:0]     pht_index_o,
    // BTB fill from execute
    input  logic                        btb_we_i,
    input  logic [`BP_BTB_IDX_BITS-1:0] btb_index_i,
    input  logic [31:0]                 btb_tag_i,
    input  logic [31:0]                 btb_target_i,
    input  bp_pkg::br_kind_e            btb_kind_i,
    // Counter training from execute
    input  logic                        pht_we_i,
    input  logic [`BP_GHR_BITS-1:0]     pht_index_i,
    input  logic                        pht_inc_i
);

    // Branch target buffer, one entry per index
    bp_pkg::btb_entry_t btb_q [`BP_BTB_ENTRIES];

    // Pattern history table and the global history of resolved branches
    logic [1:0]              pht_q [`BP_PHT_ENTRIES];
    logic [`BP_GHR_BITS-1:0] ghr_q;

    // Lookup side
    logic [`BP_BTB_IDX_BITS-1:0] rd_index;
    bp_pkg::btb_entry_t          rd_entry;
    logic [1:0]                  rd_counter;

    // Training side
    logic [1:0] wr_counter;
    logic [1:0] wr_counter_next;

    // The BTB index is taken straight from the word address of the PC
    assign rd_index = pc_i[`BP_BTB_IDX_BITS+1:2];
    assign rd_entry = btb_q[rd_index];

    // Gshare index folds the low word-address bits with the history
    assign pht_index_o = pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign rd_counter  = pht_q[pht_index_o];

    // A hit needs a filled entry whose stored PC is exactly this PC
    assign hit_o = rd_entry.valid && (rd_entry.tag == pc_i);

    always_comb begin
        // Default is the sequential path, used on a miss
        pred_taken_o  = 1'b0;
        pred_target_o = pc_i + `BP_INSTR_BYTES;
        if (hit_o && (rd_entry.kind == bp_pkg::BR_JUMP)) begin
            // Unconditional, so always go to the learned target
            pred_taken_o  = 1'b1;
            pred_target_o = rd_entry.target;
        end else if (hit_o && (rd_entry.kind == bp_pkg::BR_BRANCH)) begin
            // Direction comes from the counter MSB
            // The stored target is passed along even when not-taken is predicted
            pred_taken_o  = rd_counter[1];
            pred_target_o = rd_entry.target;
        end
    end

    // Saturating update of the counter being trained
    assign wr_counter = pht_q[pht_index_i];

    always_comb begin
        wr_counter_next = wr_counter;
        if (pht_inc_i && (wr_counter != 2'b11)) begin
            wr_counter_next = wr_counter + 2'd1;
        end else if (!pht_inc_i && (wr_counter != 2'b00)) begin
            wr_counter_next = wr_counter - 2'd1;
        end
    end

    // BTB storage
    // Execute fills one whole entry per write request
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                btb_q[i].valid <= 1'b0;
            end
        end else if (btb_we_i) begin
            btb_q[btb_index_i].valid  <= 1'b1;
            btb_q[btb_index_i].tag    <= btb_tag_i;
            btb_q[btb_index_i].target <= btb_target_i;
            btb_q[btb_index_i].kind   <= btb_kind_i;
        end
    end

    // Counters restart weakly not-taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                pht_q[i] <= `BP_PHT_INIT;
            end
        end else if (pht_we_i) begin
            pht_q[pht_index_i] <= wr_counter_next;
        end
    end

    // History moves only on resolved conditional branches
    // The newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (pht_we_i) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], pht_inc_i};
        end
    end

endmodule

// File: rtl/bp_decode_stage.sv
// Fetch-to-decode pipeline register with opcode classification
`timescale 1ns/1ns

`include "bp_macros.svh"

module bp_decode_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    kill_i,
    // From fetch and the predictor
    input  logic                    valid_i,
    input  logic [31:0]             pc_i,
    input  logic [6:0]              op_i,
    input  logic                    hit_i,
    input  logic                    pred_taken_i,
    input  logic [31:0]             pred_target_i,
    input  logic [`BP_GHR_BITS-1:0] pht_index_i,
    // Toward execute
    output logic                    valid_o,
    output logic [31:0]             pc_o,
    output logic [6:0]              op_o,
    output logic                    hit_o,
    output logic                    pred_taken_o,
    output logic [31:0]             pred_target_o,
    output logic [`BP_GHR_BITS-1:0] pht_index_o,
    output bp_pkg::br_kind_e        kind_o
);

    // The valid bit is the only control state here
    // A kill drops whatever sits in the fetch slot this cycle
    always_ff @(posedge clk) begin
        if (reset_i || kill_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload follows the fetch every cycle and is qualified by valid_o
    always_ff @(posedge clk) begin
        pc_o          <= pc_i;
        op_o          <= op_i;
        hit_o         <= hit_i;
        pred_taken_o  <= pred_taken_i;
        pred_target_o <= pred_target_i;
        pht_index_o   <= pht_index_i;
    end

    // Classify the registered opcode
    // JAL and JALR both count as jumps, anything unknown is plain
    always_comb begin
        case (op_o)
            `BP_OP_JAL, `BP_OP_JALR: kind_o = bp_pkg::BR_JUMP;
            `BP_OP_BRANCH:           kind_o = bp_pkg::BR_BRANCH;
            default:                 kind_o = bp_pkg::BR_NONE;
        endcase
    end

endmodule

// File: rtl/bp_execute_stage.sv
// Decode-to-execute register that resolves the prediction and drives training and redirect
`timescale 1ns/1ns

`include "bp_macros.svh"

module bp_execute_stage (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        kill_i,
    // From decode
    input  logic                        valid_i,
    input  logic [31:0]                 pc_i,
    input  logic [6:0]                  op_i,
    input  logic                        hit_i,
    input  logic                        pred_taken_i,
    input  logic [31:0]                 pred_target_i,
    input  logic [`BP_GHR_BITS-1:0]     pht_index_i,
    input  bp_pkg::br_kind_e            kind_i,
    // Outcome for the instruction held here, meaningful only while it is valid
    input  logic                        resolved_taken_i,
    input  logic [31:0]                 resolved_target_i,
    // BTB fill request
    output logic                        btb_we_o,
    output logic [`BP_BTB_IDX_BITS-1:0] btb_index_o,
    output logic [31:0]                 btb_tag_o,
    output logic [31:0]                 btb_target_o,
    output bp_pkg::br_kind_e            btb_kind_o,
    // Counter training request
    output logic                        pht_we_o,
    output logic [`BP_GHR_BITS-1:0]     pht_index_o,
    output logic                        pht_inc_o,
    // Redirect request
    output logic                        mispredict_o,
    output logic [31:0]                 correct_pc_o
);

    logic                    valid_q;
    logic [31:0]             pc_q;
    logic [6:0]              op_q;
    logic                    hit_q;
    logic                    pred_taken_q;
    logic [31:0]             pred_target_q;
    logic [`BP_GHR_BITS-1:0] pht_index_q;
    bp_pkg::br_kind_e        kind_q;

    logic is_cond;
    logic target_wrong;
    logic learnable;

    // A kill here removes the instruction coming up from decode
    always_ff @(posedge clk) begin
        if (reset_i || kill_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_q          <= pc_i;
        op_q          <= op_i;
        hit_q         <= hit_i;
        pred_taken_q  <= pred_taken_i;
        pred_target_q <= pred_target_i;
        pht_index_q   <= pht_index_i;
        kind_q        <= kind_i;
    end

    // Only conditional branches train the counters and the history
    assign is_cond      = (op_q == `BP_OP_BRANCH);
    assign target_wrong = (pred_target_q != resolved_target_i);

    // Jumps and taken branches are the ones worth remembering in the BTB
    assign learnable = (kind_q == bp_pkg::BR_JUMP) ||
                       ((kind_q == bp_pkg::BR_BRANCH) && resolved_taken_i);

    // Wrong direction, or right direction (taken) with the wrong target
    assign mispredict_o = valid_q &&
                          ((pred_taken_q != resolved_taken_i) ||
                           (pred_taken_q && resolved_taken_i && target_wrong));

    // Where fetch should have gone
    assign correct_pc_o = resolved_taken_i ? resolved_target_i : pc_q + `BP_INSTR_BYTES;

    // Fill on a lookup miss, or when the stored target turned out stale
    assign btb_we_o     = valid_q && learnable && (!hit_q || target_wrong);
    assign btb_index_o  = pc_q[`BP_BTB_IDX_BITS+1:2];
    assign btb_tag_o    = pc_q;
    assign btb_target_o = resolved_target_i;
    assign btb_kind_o   = kind_q;

    // The counter read at fetch is the one trained
    assign pht_we_o    = valid_q && is_cond;
    assign pht_index_o = pht_index_q;
    assign pht_inc_o   = resolved_taken_i;

endmodule

// File: rtl/bp_redirect_unit.sv
// Redirect register toward fetch and the squash of younger pipeline slots
`timescale 1ns/1ns

module bp_redirect_unit (
    input  logic        clk,
    input  logic        reset_i,
    // From execute
    input  logic        mispredict_i,
    input  logic [31:0] correct_pc_i,
    // Flush of the fetch slot and of decode
    output logic        kill_o,
    // Registered redirect for the front end
    output logic        redirect_valid_o,
    output logic [31:0] redirect_pc_o
);

    // Everything younger than the mispredicting instruction is wrong path
    // The squash acts in the same cycle, so it is not registered
    assign kill_o = mispredict_i;

    // One pulse per mispredict
    // Execute cannot mispredict two cycles in a row because the kill empties it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= mispredict_i;
        end
    end

    // Redirect PC is qualified by redirect_valid_o
    always_ff @(posedge clk) begin
        if (mispredict_i) begin
            redirect_pc_o <= correct_pc_i;
        end
    end

endmodule

// File: rtl/bp_frontend_top.sv
// Branch prediction front end: predictor, decode, execute and redirect unit
`timescale 1ns/1ns

`include "bp_macros.svh"

module bp_frontend_top (
    input  logic        clk,
    input  logic        reset_i,
    // Fetch slot
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [6:0]  fetch_op_i,
    // Outcome of the instruction in execute
    input  logic        resolved_taken_i,
    input  logic [31:0] resolved_target_i,
    // Prediction for the fetch slot
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    // Redirect after a mispredict
    output logic        redirect_valid_o,
    output logic [31:0] redirect_pc_o
);

    // Predictor side info for the fetch slot
    logic                    f_hit;
    logic [`BP_GHR_BITS-1:0] f_pht_index;

    // Decode stage outputs
    logic                    d_valid;
    logic [31:0]             d_pc;
    logic [6:0]              d_op;
    logic                    d_hit;
    logic                    d_pred_taken;
    logic [31:0]             d_pred_target;
    logic [`BP_GHR_BITS-1:0] d_pht_index;
    bp_pkg::br_kind_e        d_kind;

    // Training requests from execute
    logic                        btb_we;
    logic [`BP_BTB_IDX_BITS-1:0] btb_index;
    logic [31:0]                 btb_tag;
    logic [31:0]                 btb_target;
    bp_pkg::br_kind_e            btb_kind;
    logic                        pht_we;
    logic [`BP_GHR_BITS-1:0]     pht_index;
    logic                        pht_inc;

    // Redirect path
    logic        mispredict;
    logic [31:0] correct_pc;
    logic        kill;

    bp_predictor u_bp_predictor (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (fetch_pc_i),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .hit_o         (f_hit),
        .pht_index_o   (f_pht_index),
        .btb_we_i      (btb_we),
        .btb_index_i   (btb_index),
        .btb_tag_i     (btb_tag),
        .btb_target_i  (btb_target),
        .btb_kind_i    (btb_kind),
        .pht_we_i      (pht_we),
        .pht_index_i   (pht_index),
        .pht_inc_i     (pht_inc)
    );

    bp_decode_stage u_bp_decode_stage (
        .clk           (clk),
        .reset_i       (reset_i),
        .kill_i        (kill),
        .valid_i       (fetch_valid_i),
        .pc_i          (fetch_pc_i),
        .op_i          (fetch_op_i),
        .hit_i         (f_hit),
        .pred_taken_i  (pred_taken_o),
        .pred_target_i (pred_target_o),
        .pht_index_i   (f_pht_index),
        .valid_o       (d_valid),
        .pc_o          (d_pc),
        .op_o          (d_op),
        .hit_o         (d_hit),
        .pred_taken_o  (d_pred_taken),
        .pred_target_o (d_pred_target),
        .pht_index_o   (d_pht_index),
        .kind_o        (d_kind)
    );

    bp_execute_stage u_bp_execute_stage (
        .clk               (clk),
        .reset_i           (reset_i),
        .kill_i            (kill),
        .valid_i           (d_valid),
        .pc_i              (d_pc),
        .op_i              (d_op),
        .hit_i             (d_hit),
        .pred_taken_i      (d_pred_taken),
        .pred_target_i     (d_pred_target),
        .pht_index_i       (d_pht_index),
        .kind_i            (d_kind),
        .resolved_taken_i  (resolved_taken_i),
        .resolved_target_i (resolved_target_i),
        .btb_we_o          (btb_we),
        .btb_index_o       (btb_index),
        .btb_tag_o         (btb_tag),
        .btb_target_o      (btb_target),
        .btb_kind_o        (btb_kind),
        .pht_we_o          (pht_we),
        .pht_index_o       (pht_index),
        .pht_inc_o         (pht_inc),
        .mispredict_o      (mispredict),
        .correct_pc_o      (correct_pc)
    );

    bp_redirect_unit u_bp_redirect_unit (
        .clk              (clk),
        .reset_i          (reset_i),
        .mispredict_i     (mispredict),
        .correct_pc_i     (correct_pc),
        .kill_o           (kill),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

// File: dv/bp_checker.sv
// Reference model of the predictor and pipeline, with output comparison and per-test reporting
`timescale 1ns/1ns

`include "bp_macros.svh"

module bp_checker (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        done_i,
    // Stimulus as seen by the DUT
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [6:0]  fetch_op_i,
    input  logic        resolved_taken_i,
    input  logic [31:0] resolved_target_i,
    input  logic [7:0]  test_id_i,
    // DUT responses
    input  logic        pred_taken_i,
    input  logic [31:0] pred_target_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    output int          error_count_o
);

    // One instruction in flight, tagged with the test it belongs to
    typedef struct packed {
        logic                    valid;
        logic [31:0]             pc;
        logic [6:0]              op;
        logic                    hit;
        logic                    taken;
        logic [31:0]             target;
        logic [`BP_GHR_BITS-1:0] pidx;
        logic [7:0]              tid;
    } slot_t;

    bp_pkg::btb_entry_t      btb [`BP_BTB_ENTRIES];
    logic [1:0]              pht [`BP_PHT_ENTRIES];
    logic [`BP_GHR_BITS-1:0] ghr;

    slot_t fs;
    slot_t ds;
    slot_t es;
    bp_pkg::btb_entry_t ent;
    bp_pkg::br_kind_e   ekind;
    logic               mis;
    logic               exp_rv;
    logic [31:0]        exp_rpc;
    logic [7:0]         exp_tid;
    logic [7:0]         tid_hist [3];
    int                 test_errs [256];
    int                 tests_passed;
    int                 tests_failed;
    logic               summary_done;

    // Opcode classes straight from the RISC-V major opcodes
    function automatic bp_pkg::br_kind_e kind_of(input logic [6:0] op);
        if (op == `BP_OP_JAL || op == `BP_OP_JALR) begin
            return bp_pkg::BR_JUMP;
        end else if (op == `BP_OP_BRANCH) begin
            return bp_pkg::BR_BRANCH;
        end
        return bp_pkg::BR_NONE;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected, input logic [7:0] tid);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
            error_count_o++;
            test_errs[tid]++;
        end
    endtask

    initial begin
        error_count_o = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        summary_done  = 1'b0;
        exp_rv        = 1'b0;
        for (int i = 0; i < 256; i++) begin
            test_errs[i] = 0;
        end
        for (int i = 0; i < 3; i++) begin
            tid_hist[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                btb[i] = '0;
            end
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                pht[i] = `BP_PHT_INIT;
            end
            ghr     = '0;
            ds      = '0;
            es      = '0;
            exp_rv  = 1'b0;
            exp_tid = '0;
        end else begin
            // Lookup for the fetch slot, against the tables as they were before this edge
            fs        = '0;
            fs.valid  = fetch_valid_i;
            fs.pc     = fetch_pc_i;
            fs.op     = fetch_op_i;
            fs.tid    = test_id_i;
            ent       = btb[fetch_pc_i[`BP_BTB_IDX_BITS+1:2]];
            fs.hit    = ent.valid && (ent.tag == fetch_pc_i);
            fs.pidx   = fetch_pc_i[`BP_GHR_BITS+1:2] ^ ghr;
            fs.taken  = 1'b0;
            fs.target = fetch_pc_i + `BP_INSTR_BYTES;
            if (fs.hit && ent.kind == bp_pkg::BR_JUMP) begin
                fs.taken  = 1'b1;
                fs.target = ent.target;
            end else if (fs.hit && ent.kind == bp_pkg::BR_BRANCH) begin
                fs.taken  = pht[fs.pidx][1];
                fs.target = ent.target;
            end
            if (fs.valid) begin
                check_value("pred_taken_o", pred_taken_i, fs.taken, fs.tid);
                check_value("pred_target_o", pred_target_i, fs.target, fs.tid);
            end

            // Redirect belonging to the execute cycle that just ended
            check_value("redirect_valid_o", redirect_valid_i, exp_rv, exp_tid);
            if (exp_rv) begin
                check_value("redirect_pc_o", redirect_pc_i, exp_rpc, exp_tid);
            end

            // Resolve the instruction in execute
            ekind   = kind_of(es.op);
            mis     = es.valid && ((es.taken != resolved_taken_i) ||
                      (es.taken && resolved_taken_i && es.target != resolved_target_i));
            exp_rv  = mis;
            exp_tid = es.tid;
            exp_rpc = resolved_taken_i ? resolved_target_i : es.pc + `BP_INSTR_BYTES;

            if (es.valid && (ekind == bp_pkg::BR_JUMP ||
                    (ekind == bp_pkg::BR_BRANCH && resolved_taken_i)) &&
                    (!es.hit || es.target != resolved_target_i)) begin
                btb[es.pc[`BP_BTB_IDX_BITS+1:2]] = '{valid: 1'b1, tag: es.pc,
                    target: resolved_target_i, kind: ekind};
            end

            if (es.valid && ekind == bp_pkg::BR_BRANCH) begin
                if (resolved_taken_i && pht[es.pidx] != 2'b11) begin
                    pht[es.pidx] = pht[es.pidx] + 2'd1;
                end else if (!resolved_taken_i && pht[es.pidx] != 2'b00) begin
                    pht[es.pidx] = pht[es.pidx] - 2'd1;
                end
                ghr = {ghr[`BP_GHR_BITS-2:0], resolved_taken_i};
            end

            // A mispredict empties decode and execute as the pipeline advances
            // Squashed slots keep their test number so that errors land on the right test
            es = ds;
            ds = fs;
            if (mis) begin
                es.valid = 1'b0;
                ds.valid = 1'b0;
            end
        end

        // A test is done once its last row has had its redirect checked
        if (tid_hist[2] != tid_hist[1] && tid_hist[2] != 0) begin
            if (test_errs[tid_hist[2]] == 0) begin
                $display("test %0d passed", tid_hist[2]);
                tests_passed++;
            end else begin
                $display("test %0d failed with %0d errors", tid_hist[2],
                         test_errs[tid_hist[2]]);
                tests_failed++;
            end
        end
        tid_hist[2] = tid_hist[1];
        tid_hist[1] = tid_hist[0];
        tid_hist[0] = reset_i ? 8'd0 : test_id_i;

        if (done_i && !summary_done) begin
            $display("%0d tests passed, %0d tests failed, %0d check errors",
                     tests_passed, tests_failed, error_count_o);
            summary_done = 1'b1;
        end
    end

endmodule

// File: dv/bp_tb.sv
// Testbench top: clock, reset, DUT, checker, file-driven stimulus and cycle limit
`timescale 1ns/1ns

module bp_tb;

    logic        clk;
    logic        reset_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic [6:0]  fetch_op_i;
    logic        resolved_taken_i;
    logic [31:0] resolved_target_i;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        redirect_valid_o;
    logic [31:0] redirect_pc_o;
    logic [7:0]  test_id;
    logic        done;
    int          error_count;
    int          file_errors;

    // Stimulus rows as read from the file
    logic        row_valid [$];
    logic [31:0] row_pc [$];
    logic [6:0]  row_op [$];
    logic        row_taken [$];
    logic [31:0] row_target [$];
    logic [7:0]  row_test [$];

    int          fd;
    int          nfields;
    string       line;
    logic        f_valid;
    logic [31:0] f_pc;
    logic [6:0]  f_op;
    logic        f_taken;
    logic [31:0] f_target;
    int          f_test;
    int          cycle_count;
    int          cycle_limit;

    bp_frontend_top u_bp_frontend_top (
        .clk               (clk),
        .reset_i           (reset_i),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_pc_i        (fetch_pc_i),
        .fetch_op_i        (fetch_op_i),
        .resolved_taken_i  (resolved_taken_i),
        .resolved_target_i (resolved_target_i),
        .pred_taken_o      (pred_taken_o),
        .pred_target_o     (pred_target_o),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_pc_o     (redirect_pc_o)
    );

    bp_checker u_bp_checker (
        .clk               (clk),
        .reset_i           (reset_i),
        .done_i            (done),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_pc_i        (fetch_pc_i),
        .fetch_op_i        (fetch_op_i),
        .resolved_taken_i  (resolved_taken_i),
        .resolved_target_i (resolved_target_i),
        .test_id_i         (test_id),
        .pred_taken_i      (pred_taken_o),
        .pred_target_i     (pred_target_o),
        .redirect_valid_i  (redirect_valid_o),
        .redirect_pc_i     (redirect_pc_o),
        .error_count_o     (error_count)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // The run limit is set from the row count once the file is read
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        clk               = 1'b0;
        reset_i           = 1'b1;
        fetch_valid_i     = 1'b0;
        fetch_pc_i        = '0;
        fetch_op_i        = '0;
        resolved_taken_i  = 1'b0;
        resolved_target_i = '0;
        test_id           = '0;
        done              = 1'b0;
        file_errors       = 0;
        cycle_count       = 0;
        cycle_limit       = 1000;

        fd = $fopen("dv/bp_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/bp_input.txt");
            $display("Errors found");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Blank lines and lines starting with # are skipped
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    nfields = $sscanf(line, "%h %h %h %h %h %d",
                                      f_valid, f_pc, f_op, f_taken, f_target, f_test);
                    if (nfields == 6) begin
                        row_valid.push_back(f_valid);
                        row_pc.push_back(f_pc);
                        row_op.push_back(f_op);
                        row_taken.push_back(f_taken);
                        row_target.push_back(f_target);
                        row_test.push_back(f_test[7:0]);
                    end else begin
                        $display("Stimulus line with %0d fields instead of 6 was skipped",
                                 nfields);
                        file_errors++;
                    end
                end
            end
            $fclose(fd);
            if (row_pc.size() == 0) begin
                $display("The stimulus file dv/bp_input.txt holds no rows");
                file_errors++;
            end
            cycle_limit = row_pc.size() + 10 + 20;

            repeat (10) @(posedge clk);
            @(negedge clk);
            reset_i = 1'b0;
            for (int i = 0; i < row_pc.size(); i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                fetch_valid_i     = row_valid[i];
                fetch_pc_i        = row_pc[i];
                fetch_op_i        = row_op[i];
                resolved_taken_i  = row_taken[i];
                resolved_target_i = row_target[i];
                test_id           = row_test[i];
            end

            // Let the last rows drain before the summary
            @(negedge clk);
            fetch_valid_i    = 1'b0;
            resolved_taken_i = 1'b0;
            test_id          = '0;
            repeat (2) @(negedge clk);
            done = 1'b1;
            @(negedge clk);
            if (error_count == 0 && file_errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_predictor.sv
rtl/bp_decode_stage.sv
rtl/bp_execute_stage.sv
rtl/bp_redirect_unit.sv
rtl/bp_frontend_top.sv
dv/bp_checker.sv
dv/bp_tb.sv

// File: Bender.yml
package:
  name: bp_frontend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bp_pkg.sv
      - rtl/bp_predictor.sv
      - rtl/bp_decode_stage.sv
      - rtl/bp_execute_stage.sv
      - rtl/bp_redirect_unit.sv
      - rtl/bp_frontend_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/bp_checker.sv
      - dv/bp_tb.sv

// File: dv/bp_input.txt
# valid pc opcode resolved_taken resolved_target test
# resolution columns belong to the row two lines up
1 00000100 13 0 00000000 1
1 00000104 13 0 00000000 1
1 00000108 13 0 00000000 1
1 0000010c 13 0 00000000 1
1 00000110 13 0 00000000 1
1 00000200 6f 0 00000000 2
1 00000204 13 0 00000000 2
1 00000208 13 1 00000400 2
0 00000000 00 0 00000000 2
1 00000200 6f 0 00000000 2
1 00000400 13 0 00000000 2
1 00000404 13 1 00000400 2
0 00000000 00 0 00000000 2
0 00000000 00 0 00000000 2
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 3
0 00000000 00 0 00000000 3
0 00000000 00 1 00000380 3
1 00000324 63 0 00000000 4
0 00000000 00 0 00000000 4
0 00000000 00 1 00000380 4
1 00000324 63 0 00000000 4
0 00000000 00 0 00000000 4
0 00000000 00 0 00000000 4
1 00000324 63 0 00000000 4
0 00000000 00 0 00000000 4
0 00000000 00 0 00000000 4
1 00000704 6f 0 00000000 5
1 00000500 6f 0 00000000 5
1 00000508 6f 1 00000800 5
0 00000000 00 1 00000600 5
0 00000000 00 1 00000700 5
1 00000500 6f 0 00000000 5
1 00000508 6f 0 00000000 5
1 00000704 6f 1 00000600 5
0 00000000 00 1 00000600 5
0 00000000 00 0 00000000 5
0 00000000 00 0 00000000 0
0 00000000 00 0 00000000 0
0 00000000 00 0 00000000 0
0 00000000 00 0 00000000 0
